//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_top
FLIST     ?= flist.f
PASS_MSG  := sim passed
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
verilog/vcp_pkg.sv
verilog/vcp_stage_if.sv
verilog/vcp_decode.sv
verilog/vc_regbank.sv
verilog/vs_regbank.sv
verilog/vcp_writeback.sv
verilog/vcp_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- testbench/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker
(
  input logic        clk,
  input logic        resetn,
  input logic [31:0] scalar_out,
  input logic        scalar_out_en,
  input logic        scalar_out_wait
);

  logic [31:0] exp_q[$];  // cfc2 results still due, in program order
  int          mismatches = 0;
  int          extras     = 0;
  int          got_count  = 0;

  task automatic add_expected(input logic [31:0] value);
    exp_q.push_back(value);
  endtask

  function automatic int missing_count();
    return exp_q.size();
  endfunction

  // outputs are settled by the falling edge, a transfer completes at the next rise
  always @(negedge clk)
  begin
    logic [31:0] want;
    if (resetn && scalar_out_en && !scalar_out_wait)
    begin
      got_count = got_count + 1;
      if (exp_q.size() == 0)
      begin
        extras = extras + 1;
        $display("unexpected result %08h at %0t ns, no cfc2 result was due",
                 scalar_out, $time);
      end
      else
      begin
        want = exp_q.pop_front();
        if (scalar_out !== want)
        begin
          mismatches = mismatches + 1;
          $display("Fail at %0t ns: scalar_out %08h, expected %08h (result %0d)",
                   $time, scalar_out, want, got_count);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  localparam int MAX_LINES = 256;
  localparam int CYC_LINE  = 200;  // watchdog budget per trace line

  logic        clk;
  logic        resetn;
  logic [31:0] instr;
  logic        instr_en;
  logic        instr_wait;
  logic [31:0] scalar_in;
  logic        scalar_in_en;
  logic        scalar_in_wait;
  logic [31:0] scalar_out;
  logic        scalar_out_en;
  logic        scalar_out_wait;

  logic [31:0] trace_mem [0:3*MAX_LINES-1];  // instr, scalar_in, expected per line
  logic [31:0] instr_q[$];
  logic [31:0] sin_q[$];
  int          n_lines = 0;
  int          n_exp   = 0;
  logic        loaded  = 1'b0;

  vcp_top #(.MVL(64)) dut_i (
    .clk             (clk),
    .resetn          (resetn),
    .instr           (instr),
    .instr_en        (instr_en),
    .instr_wait      (instr_wait),
    .scalar_in       (scalar_in),
    .scalar_in_en    (scalar_in_en),
    .scalar_in_wait  (scalar_in_wait),
    .scalar_out      (scalar_out),
    .scalar_out_en   (scalar_out_en),
    .scalar_out_wait (scalar_out_wait)
  );

  tb_checker checker_i (
    .clk             (clk),
    .resetn          (resetn),
    .scalar_out      (scalar_out),
    .scalar_out_en   (scalar_out_en),
    .scalar_out_wait (scalar_out_wait)
  );

  function automatic logic is_cfc2(input logic [31:0] w);
    return w[31:26] == 6'b010010 && w[25:22] == 4'b0001 && w[5:0] == 6'd0;
  endfunction

  // ctc2 and mtc2 both take a word from scalar_in
  function automatic logic takes_scalar(input logic [31:0] w);
    return w[31:26] == 6'b010010 && w[5:0] == 6'd0 &&
           (w[25:22] == 4'b0011 || w[25:22] == 4'b0010);
  endfunction

  // marks entries the trace did not fill, never a cop2 word
  function automatic logic [31:0] fill_word(input int addr);
    return ~addr;
  endfunction

  initial
  begin
    clk = 1'b0;
    forever
      #50 clk = ~clk;
  end

  task automatic load_trace();
    for (int i = 0; i < 3*MAX_LINES; i++)
      trace_mem[i] = fill_word(i);
    $readmemh("testbench/vcp_trace.txt", trace_mem);
    while (n_lines < MAX_LINES && trace_mem[3*n_lines] != fill_word(3*n_lines))
    begin
      instr_q.push_back(trace_mem[3*n_lines]);
      if (takes_scalar(trace_mem[3*n_lines]))
        sin_q.push_back(trace_mem[3*n_lines+1]);
      if (is_cfc2(trace_mem[3*n_lines]))
      begin
        checker_i.add_expected(trace_mem[3*n_lines+2]);
        n_exp = n_exp + 1;
      end
      n_lines = n_lines + 1;
    end
  endtask

  // hold each word until a falling edge shows instr_wait low
  task automatic issue_instrs();
    while (instr_q.size() > 0)
    begin
      instr    = instr_q[0];
      instr_en = 1'b1;
      @(negedge clk);
      while (instr_wait)
      begin
        @(posedge clk);
        #10;
        @(negedge clk);
      end
      @(posedge clk);
      #10;
      void'(instr_q.pop_front());
    end
    instr_en = 1'b0;
    instr    = '0;
  endtask

  // scalar_in offered with random gaps, popped once taken
  initial
  begin
    logic take;
    void'($urandom(35));
    wait (loaded);
    forever
    begin
      @(negedge clk);
      take = scalar_in_en && !scalar_in_wait;
      @(posedge clk);
      #10;
      if (take)
        void'(sin_q.pop_front());
      scalar_in_en    = resetn && sin_q.size() > 0 && ($urandom % 4 != 0);
      scalar_in       = (sin_q.size() > 0) ? sin_q[0] : 32'd0;
      scalar_out_wait = ($urandom % 3) == 0;
    end
  end

  initial
  begin
    wait (loaded);
    repeat (n_lines * CYC_LINE) @(posedge clk);
    $display("timeout: %0d of %0d results seen after %0d cycles",
             checker_i.got_count, n_exp, n_lines * CYC_LINE);
    $display("sim failed");
    $finish;
  end

  initial
  begin
    int missing;
    int errors;
    resetn          = 1'b0;
    instr           = '0;
    instr_en        = 1'b0;
    scalar_in       = '0;
    scalar_in_en    = 1'b0;
    scalar_out_wait = 1'b0;
    load_trace();
    loaded = 1'b1;
    repeat (4) @(posedge clk);
    #10;
    resetn = 1'b1;
    issue_instrs();
    wait (checker_i.got_count >= n_exp);
    repeat (20) @(posedge clk);  // room for any extra result to show up
    missing = checker_i.missing_count();
    if (missing > 0)
      $display("%0d expected cfc2 results never arrived", missing);
    errors = checker_i.mismatches + checker_i.extras + missing;
    $display("errors: %0d total, %0d mismatched, %0d extra, %0d missing",
             errors, checker_i.mismatches, checker_i.extras, missing);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/vcp_trace.txt
// columns: instr word, scalar_in for ctc2/mtc2, expected scalar_out for cfc2
// ctc2 to control, base, inc and stride, read back
48C01400 11110005 00000000
48C08400 22220021 00000000
48C0C800 33330032 00000000
48C0F000 4444003C 00000000
48401400 00000000 11110005
48408400 00000000 22220021
4840C800 00000000 33330032
4840F000 00000000 4444003C
48C01C00 DEADBEEF 00000000
48401C00 00000000 DEADBEEF
// mtc2 vs3, vmstc vs3 to vc9, vmcts vc5 to vs12, vmstc vs12 to vc11
48801800 CAFE0003 00000000
4A03243A 00000000 00000000
48402400 00000000 CAFE0003
4A0C143B 00000000 00000000
4A0C2C3A 00000000 00000000
48402C00 00000000 11110005
// vl, vhalf and vsatvl
48C00000 00000065 00000000
4A000031 00000000 00000000
48400000 00000000 00000032
4A000034 00000000 00000000
48400000 00000000 00000032
48C00000 000000C8 00000000
4A000034 00000000 00000000
48400000 00000000 00000040
48C00000 00000040 00000000
4A000034 00000000 00000000
48400000 00000000 00000040
// vld base update, inc written just before
48C08000 00001000 00000000
48C0C000 00000010 00000000
4B000002 00000000 00000000
48408000 00000000 00001010
4B001402 00000000 00000000
48408400 00000000 55550053

//--- verilog/vc_regbank.sv
`timescale 1ns/1ps
`default_nettype none

module vc_regbank
  import vcp_pkg::*;
(
  input  logic     clk,
  input  logic     resetn,
  input  vc_addr_t rd_vc,
  input  logic     rd_vc_en,
  input  vc_addr_t vld_base,
  input  vc_addr_t vld_inc,
  input  logic     fwd,
  input  vc_data_t wdata,
  output vc_data_t vc_rdata,
  output vc_data_t vl,
  output vc_data_t base_plus_inc,
  vcp_stage_if.bank stage
);

  vc_data_t vl_q;
  vc_data_t ctrl_q   [32];  // entry 0 is vl, kept in vl_q
  vc_data_t base_q   [16];
  vc_data_t inc_q    [8];
  vc_data_t stride_q [8];
  vc_data_t base_rd, inc_rd;
  logic     we, vl_we, ctrl_we, base_we, inc_we, stride_we;

  function automatic vc_data_t read_vc(vc_addr_t a);
    if (a == '0)
      return vl_q;
    else if (!a[5])
      return ctrl_q[a[4:0]];
    else if (!a[4])
      return base_q[a[3:0]];
    else if (!a[3])
      return inc_q[a[2:0]];
    else
      return stride_q[a[2:0]];
  endfunction

  assign we        = stage.vc_we & ~stage.stall2;
  assign vl_we     = we && stage.vc_dest == '0;
  assign ctrl_we   = we && !stage.vc_dest[5] && stage.vc_dest[4:0] != '0;
  assign base_we   = we && stage.vc_dest[5:4] == 2'b10;
  assign inc_we    = we && stage.vc_dest[5:3] == 3'b110;
  assign stride_we = we && stage.vc_dest[5:3] == 3'b111;

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      vl_q <= '0;
      for (int i = 0; i < 32; i++)
        ctrl_q[i] <= '0;
      for (int i = 0; i < 16; i++)
        base_q[i] <= '0;
      for (int i = 0; i < 8; i++)
      begin
        inc_q[i]    <= '0;
        stride_q[i] <= '0;
      end
    end
    else
    begin
      if (vl_we)     vl_q <= wdata;
      if (ctrl_we)   ctrl_q[stage.vc_dest[4:0]] <= wdata;
      if (base_we)   base_q[stage.vc_dest[3:0]] <= wdata;
      if (inc_we)    inc_q[stage.vc_dest[2:0]] <= wdata;
      if (stride_we) stride_q[stage.vc_dest[2:0]] <= wdata;
    end
  end

  // registered reads; a hit on the committing write takes wdata instead
  always_ff @(posedge clk)
  begin
    if (rd_vc_en)
    begin
      vc_rdata <= (fwd && rd_vc == stage.vc_dest) ? wdata : read_vc(rd_vc);
      base_rd  <= (fwd && vld_base == stage.vc_dest) ? wdata : read_vc(vld_base);
      inc_rd   <= (fwd && vld_inc == stage.vc_dest) ? wdata : read_vc(vld_inc);
    end
  end

  assign base_plus_inc = base_rd + inc_rd;  // vld base update
  assign vl            = vl_q;              // read live in stage 2 by vhalf/vsatvl

  a_one_array: assert property (@(posedge clk) disable iff (!resetn)
    $onehot0({vl_we, ctrl_we, base_we, inc_we, stride_we}))
    else $error("more than one control array written");

endmodule

`default_nettype wire

//--- verilog/vcp_decode.sv
`timescale 1ns/1ps
`default_nettype none

module vcp_decode
  import vcp_pkg::*;
(
  input  logic      clk,
  input  logic      resetn,
  input  instr_t    instr,
  input  logic      instr_en,
  output logic      instr_wait,
  input  logic      scalar_in_en,
  input  logic      stall3,
  input  logic      vs_busy,
  output vc_addr_t  rd_vc,
  output logic      rd_vc_en,
  output vs_addr_t  rd_vs,
  output logic      rd_vs_en,
  output logic      fwd,
  output vc_addr_t  vld_base,
  output vc_addr_t  vld_inc,
  vcp_stage_if.decode stage
);

  instr_t     ir;
  vcp_op_e    op;
  logic       is_cop2;
  logic       stall1, stall2, squash1;
  logic       haz_vs;
  logic       rd_vc_need, rd_vs_need;
  logic       vc_we_d, vs_we_d, sin_d, sout_d;
  vc_addr_t   vc_dest_d;
  vs_addr_t   vs_dest_d;
  wdata_sel_e wsel_d;
  logic       vc_we_q, vs_we_q, sin_q, sout_q;

  assign is_cop2 = instr[31:26] == COP2_MAJOR;

  // anything that is not cop2 enters as a nop
  always_ff @(posedge clk)
  begin
    if (!resetn)
      ir <= '0;
    else if (!stall1)
      ir <= (instr_en && is_cop2) ? instr : '0;
  end

  assign instr_wait = stall1 & instr_en & is_cop2;

  assign op       = vcp_op_e'({ir[OP_HI_MSB:OP_HI_LSB], ir[OP_LO_MSB:OP_LO_LSB]});
  assign rd_vc    = ir[VCR_MSB:VCR_LSB];
  assign rd_vs    = ir[SRC2_MSB:SRC2_LSB];
  assign vld_base = {BASE_PREFIX, ir[BASE_MSB:BASE_LSB]};
  assign vld_inc  = {INC_PREFIX, ir[INC_MSB:INC_LSB]};

  always_comb
  begin
    rd_vc_need = 1'b0;
    rd_vs_need = 1'b0;
    vc_we_d    = 1'b0;
    vs_we_d    = 1'b0;
    sin_d      = 1'b0;
    sout_d     = 1'b0;
    vc_dest_d  = ir[VCR_MSB:VCR_LSB];
    vs_dest_d  = ir[VSR_MSB:VSR_LSB];
    wsel_d     = WD_SCALAR;
    case (op)
      OP_CTC2:
      begin
        vc_we_d = 1'b1;
        sin_d   = 1'b1;
      end
      OP_MTC2:
      begin
        vs_we_d = 1'b1;
        sin_d   = 1'b1;
      end
      OP_CFC2:
      begin
        rd_vc_need = 1'b1;
        sout_d     = 1'b1;
      end
      OP_VMSTC:
      begin
        rd_vs_need = 1'b1;
        vc_we_d    = 1'b1;
      end
      OP_VMCTS:
      begin
        rd_vc_need = 1'b1;
        vs_we_d    = 1'b1;
        vs_dest_d  = ir[SRC2_MSB:SRC2_LSB];
      end
      OP_VHALF:
      begin
        vc_we_d   = 1'b1;
        vc_dest_d = '0;  // vl
        wsel_d    = WD_VHALF;
      end
      OP_VSATVL:
      begin
        vc_we_d   = 1'b1;
        vc_dest_d = '0;
        wsel_d    = WD_VSATVL;
      end
      OP_VLD:
      begin
        rd_vc_need = 1'b1;  // base and inc
        vc_we_d    = 1'b1;
        vc_dest_d  = vld_base;
        wsel_d     = WD_BASEINC;
      end
      default:
      begin
      end
    endcase
  end

  // coarse check on the scalar bank, register numbers are not compared
  assign haz_vs  = rd_vs_need & vs_busy;
  assign stall2  = stall3 | (sin_q & ~scalar_in_en);
  assign stall1  = stall2 | haz_vs;
  assign squash1 = stall1 & ~stall2;  // bubble into stage 2

  assign rd_vc_en = rd_vc_need & ~stall1;
  assign rd_vs_en = rd_vs_need & ~stall1;

  // stage 1 reads what stage 2 writes at the same edge
  assign fwd = rd_vc_need & vc_we_q &
               ((rd_vc == stage.vc_dest) || (vld_base == stage.vc_dest) ||
                (vld_inc == stage.vc_dest));

  always_ff @(posedge clk)
  begin
    if (!resetn || squash1)
    begin
      vc_we_q <= 1'b0;
      vs_we_q <= 1'b0;
      sin_q   <= 1'b0;
      sout_q  <= 1'b0;
    end
    else if (!stall1)
    begin
      vc_we_q <= vc_we_d;
      vs_we_q <= vs_we_d;
      sin_q   <= sin_d;
      sout_q  <= sout_d;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stall1)
    begin
      stage.vc_dest   <= vc_dest_d;
      stage.vs_dest   <= vs_dest_d;
      stage.wdata_sel <= wsel_d;
    end
  end

  assign stage.vc_we            = vc_we_q;
  assign stage.vs_we            = vs_we_q & ~stall2;
  assign stage.scalar_in_needed = sin_q;
  assign stage.scalar_out_req   = sout_q;
  assign stage.stall2           = stall2;

  a_wait_needs_en: assert property (@(posedge clk) disable iff (!resetn)
    !instr_en |-> !instr_wait)
    else $error("instr_wait raised without instr_en");

endmodule

`default_nettype wire

//--- verilog/vcp_pkg.sv
`default_nettype none

package vcp_pkg;

  localparam int VCWIDTH = 32;

  typedef logic [VCWIDTH-1:0] vc_data_t;
  typedef logic [5:0]         vc_addr_t;  // 0-31 ctrl, 32-47 base, 48-55 inc, 56-63 stride
  typedef logic [4:0]         vs_addr_t;
  typedef logic [31:0]        instr_t;

  localparam logic [5:0] COP2_MAJOR = 6'b010010;  // instr[31:26]

  // kept operations, keyed on {instr[25:22], instr[5:0]}
  typedef enum logic [9:0] {
    OP_NOP    = 10'b0000_000000,
    OP_CFC2   = 10'b0001_000000,
    OP_MTC2   = 10'b0010_000000,
    OP_CTC2   = 10'b0011_000000,
    OP_VHALF  = 10'b1000_110001,
    OP_VSATVL = 10'b1000_110100,
    OP_VMSTC  = 10'b1000_111010,
    OP_VMCTS  = 10'b1000_111011,
    OP_VLD    = 10'b1100_000010
  } vcp_op_e;

  // control write data source; WD_SCALAR picks scalar_in or a vs read
  typedef enum logic [1:0] {
    WD_SCALAR  = 2'd0,
    WD_VHALF   = 2'd1,
    WD_VSATVL  = 2'd2,
    WD_BASEINC = 2'd3
  } wdata_sel_e;

  // instruction fields
  localparam int OP_HI_MSB = 25;
  localparam int OP_HI_LSB = 22;
  localparam int OP_LO_MSB = 5;
  localparam int OP_LO_LSB = 0;
  localparam int VCR_MSB   = 15;
  localparam int VCR_LSB   = 10;
  localparam int VSR_MSB   = 15;
  localparam int VSR_LSB   = 11;
  localparam int SRC2_MSB  = 20;
  localparam int SRC2_LSB  = 16;
  localparam int BASE_MSB  = 15;
  localparam int BASE_LSB  = 12;
  localparam int INC_MSB   = 11;
  localparam int INC_LSB   = 9;

  localparam logic [1:0] BASE_PREFIX = 2'b10;   // vc32..47
  localparam logic [2:0] INC_PREFIX  = 3'b110;  // vc48..55

endpackage

`default_nettype wire

//--- verilog/vcp_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// stage-2 write control, produced by decode and used by the banks and writeback
interface vcp_stage_if
  import vcp_pkg::*;
();

  logic       vc_we;             // control write pending in stage 2, not yet stall gated
  vc_addr_t   vc_dest;
  logic       vs_we;             // scalar write commit, already qualified by stall2
  vs_addr_t   vs_dest;
  wdata_sel_e wdata_sel;
  logic       scalar_in_needed;  // ctc2/mtc2 in stage 2
  logic       scalar_out_req;    // cfc2 in stage 2
  logic       stall2;

  modport decode (
    output vc_we, vc_dest, vs_we, vs_dest, wdata_sel,
    output scalar_in_needed, scalar_out_req, stall2
  );

  modport bank (
    input vc_we, vc_dest, vs_we, vs_dest, wdata_sel,
    input scalar_in_needed, scalar_out_req, stall2
  );

endinterface

`default_nettype wire

//--- verilog/vcp_top.sv
`timescale 1ns/1ps
`default_nettype none

module vcp_top
  import vcp_pkg::*;
#(
  parameter int MVL = 64
)
(
  input  logic     clk,
  input  logic     resetn,
  input  instr_t   instr,
  input  logic     instr_en,
  output logic     instr_wait,
  input  vc_data_t scalar_in,
  input  logic     scalar_in_en,
  output logic     scalar_in_wait,
  output vc_data_t scalar_out,
  output logic     scalar_out_en,
  input  logic     scalar_out_wait
);

  vc_addr_t rd_vc, vld_base, vld_inc;
  vs_addr_t rd_vs;
  logic     rd_vc_en, rd_vs_en, fwd, stall3;
  vc_data_t vc_rdata, vl, base_plus_inc, vs_rdata;
  vc_data_t wdata, vs_wdata;

  vcp_stage_if stage_i ();

  vcp_decode decode_i (
    .clk          (clk),
    .resetn       (resetn),
    .instr        (instr),
    .instr_en     (instr_en),
    .instr_wait   (instr_wait),
    .scalar_in_en (scalar_in_en),
    .stall3       (stall3),
    .vs_busy      (stage_i.vs_we),  // scalar write committing this cycle
    .rd_vc        (rd_vc),
    .rd_vc_en     (rd_vc_en),
    .rd_vs        (rd_vs),
    .rd_vs_en     (rd_vs_en),
    .fwd          (fwd),
    .vld_base     (vld_base),
    .vld_inc      (vld_inc),
    .stage        (stage_i.decode)
  );

  vc_regbank vc_bank_i (
    .clk           (clk),
    .resetn        (resetn),
    .rd_vc         (rd_vc),
    .rd_vc_en      (rd_vc_en),
    .vld_base      (vld_base),
    .vld_inc       (vld_inc),
    .fwd           (fwd),
    .wdata         (wdata),
    .vc_rdata      (vc_rdata),
    .vl            (vl),
    .base_plus_inc (base_plus_inc),
    .stage         (stage_i.bank)
  );

  vs_regbank vs_bank_i (
    .clk      (clk),
    .resetn   (resetn),
    .rd_vs    (rd_vs),
    .rd_vs_en (rd_vs_en),
    .vs_we    (stage_i.vs_we),
    .vs_dest  (stage_i.vs_dest),
    .vs_wdata (vs_wdata),
    .vs_rdata (vs_rdata)
  );

  vcp_writeback #(.MVL(MVL)) writeback_i (
    .clk             (clk),
    .resetn          (resetn),
    .vc_rdata        (vc_rdata),
    .vl              (vl),
    .base_plus_inc   (base_plus_inc),
    .vs_rdata        (vs_rdata),
    .scalar_in       (scalar_in),
    .scalar_in_en    (scalar_in_en),
    .scalar_in_wait  (scalar_in_wait),
    .scalar_out_wait (scalar_out_wait),
    .wdata           (wdata),
    .vs_wdata        (vs_wdata),
    .stall3          (stall3),
    .scalar_out      (scalar_out),
    .scalar_out_en   (scalar_out_en),
    .stage           (stage_i.bank)
  );

endmodule

`default_nettype wire

//--- verilog/vcp_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module vcp_writeback
  import vcp_pkg::*;
#(
  parameter int MVL = 64
)
(
  input  logic     clk,
  input  logic     resetn,
  input  vc_data_t vc_rdata,
  input  vc_data_t vl,
  input  vc_data_t base_plus_inc,
  input  vc_data_t vs_rdata,
  input  vc_data_t scalar_in,
  input  logic     scalar_in_en,
  output logic     scalar_in_wait,
  input  logic     scalar_out_wait,
  output vc_data_t wdata,
  output vc_data_t vs_wdata,
  output logic     stall3,
  output vc_data_t scalar_out,
  output logic     scalar_out_en,
  vcp_stage_if.bank stage
);

  localparam vc_data_t MVL_V = vc_data_t'(MVL);

  logic     s3_valid;  // cfc2 in stage 3
  logic     s3_sent;   // its result already taken by the cpu
  vc_data_t out_q;

  // stage 2 control write data
  always_comb
  begin
    case (stage.wdata_sel)
      WD_SCALAR:  wdata = stage.scalar_in_needed ? scalar_in : vs_rdata;
      WD_VHALF:   wdata = vl >> 1;
      WD_VSATVL:  wdata = (vl > MVL_V) ? MVL_V : vl;
      WD_BASEINC: wdata = base_plus_inc;
      default:    wdata = scalar_in;
    endcase
  end

  assign vs_wdata = stage.scalar_in_needed ? scalar_in : vc_rdata;  // mtc2 / vmcts

  // scalar_in is only taken by a ctc2/mtc2 that can leave stage 2
  assign scalar_in_wait = scalar_in_en & ~(stage.scalar_in_needed & ~stage.stall2);

  // stage 3
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      s3_valid <= 1'b0;
      s3_sent  <= 1'b0;
    end
    else if (!stage.stall2)
    begin
      s3_valid <= stage.scalar_out_req;
      s3_sent  <= 1'b0;
    end
    else if (scalar_out_en && !scalar_out_wait)
      s3_sent <= 1'b1;  // held in stage 3 but must not be sent twice
  end

  always_ff @(posedge clk)
  begin
    if (!stage.stall2 && stage.scalar_out_req)
      out_q <= vc_rdata;
  end

  assign scalar_out_en = s3_valid & ~s3_sent;
  assign scalar_out    = out_q;
  assign stall3        = scalar_out_en & scalar_out_wait;

  a_out_hold: assert property (@(posedge clk) disable iff (!resetn)
    scalar_out_en && scalar_out_wait |=> scalar_out_en && $stable(scalar_out))
    else $error("scalar_out changed while waiting");

endmodule

`default_nettype wire

//--- verilog/vs_regbank.sv
`timescale 1ns/1ps
`default_nettype none

module vs_regbank
  import vcp_pkg::*;
(
  input  logic     clk,
  input  logic     resetn,
  input  vs_addr_t rd_vs,
  input  logic     rd_vs_en,
  input  logic     vs_we,
  input  vs_addr_t vs_dest,
  input  vc_data_t vs_wdata,
  output vc_data_t vs_rdata
);

  vc_data_t vs_q [32];

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      for (int i = 0; i < 32; i++)
        vs_q[i] <= '0;
    end
    else if (vs_we)
      vs_q[vs_dest] <= vs_wdata;
  end

  always_ff @(posedge clk)
  begin
    if (rd_vs_en)
      vs_rdata <= vs_q[rd_vs];  // old value, write lands at the same edge
  end

  // decode holds stage 1 while a scalar write is committing
  a_no_rw_same: assert property (@(posedge clk) disable iff (!resetn)
    rd_vs_en && vs_we |-> rd_vs != vs_dest)
    else $error("vs read and write to the same register in one cycle");

endmodule

`default_nettype wire
